//--- aes_config.svh
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// Bytes in one AES state
`define AES_BYTES 16

`define AES_WIDTH 128

// Low byte of x^8 + x^4 + x^3 + x + 1
`define AES_POLY 8'h1b

`endif

//--- aesPkg.sv
`default_nettype none

`include "aes_config.svh"

package aesPkg;

        // Byte 0 is the most significant, byte 4c+r is row r of column c
        typedef logic [0:`AES_BYTES-1][7:0] stateT;

        typedef enum logic {
                ROUND_MIX   = 1'b0,  // Normal round with MixColumns
                ROUND_FINAL = 1'b1   // Last round, no MixColumns
        } roundKindT;

        typedef struct packed {
                stateT     state;
                stateT     roundKey;
                roundKindT kind;
        } roundReqT;

endpackage

`default_nettype wire

//--- subBytes.sv
`timescale 1ns/1ns
`default_nettype none

module subBytes (
        input  logic [7:0] x,
        output logic [7:0] y
);

        always_comb begin
                case (x)
                        8'h00: y = 8'h63;
                        8'h01: y = 8'h7c;
                        8'h02: y = 8'h77;
                        8'h03: y = 8'h7b;
                        8'h04: y = 8'hf2;
                        8'h05: y = 8'h6b;
                        8'h06: y = 8'h6f;
                        8'h07: y = 8'hc5;
                        8'h08: y = 8'h30;
                        8'h09: y = 8'h01;
                        8'h0a: y = 8'h67;
                        8'h0b: y = 8'h2b;
                        8'h0c: y = 8'hfe;
                        8'h0d: y = 8'hd7;
                        8'h0e: y = 8'hab;
                        8'h0f: y = 8'h76;
                        8'h10: y = 8'hca;
                        8'h11: y = 8'h82;
                        8'h12: y = 8'hc9;
                        8'h13: y = 8'h7d;
                        8'h14: y = 8'hfa;
                        8'h15: y = 8'h59;
                        8'h16: y = 8'h47;
                        8'h17: y = 8'hf0;
                        8'h18: y = 8'had;
                        8'h19: y = 8'hd4;
                        8'h1a: y = 8'ha2;
                        8'h1b: y = 8'haf;
                        8'h1c: y = 8'h9c;
                        8'h1d: y = 8'ha4;
                        8'h1e: y = 8'h72;
                        8'h1f: y = 8'hc0;
                        8'h20: y = 8'hb7;
                        8'h21: y = 8'hfd;
                        8'h22: y = 8'h93;
                        8'h23: y = 8'h26;
                        8'h24: y = 8'h36;
                        8'h25: y = 8'h3f;
                        8'h26: y = 8'hf7;
                        8'h27: y = 8'hcc;
                        8'h28: y = 8'h34;
                        8'h29: y = 8'ha5;
                        8'h2a: y = 8'he5;
                        8'h2b: y = 8'hf1;
                        8'h2c: y = 8'h71;
                        8'h2d: y = 8'hd8;
                        8'h2e: y = 8'h31;
                        8'h2f: y = 8'h15;
                        8'h30: y = 8'h04;
                        8'h31: y = 8'hc7;
                        8'h32: y = 8'h23;
                        8'h33: y = 8'hc3;
                        8'h34: y = 8'h18;
                        8'h35: y = 8'h96;
                        8'h36: y = 8'h05;
                        8'h37: y = 8'h9a;
                        8'h38: y = 8'h07;
                        8'h39: y = 8'h12;
                        8'h3a: y = 8'h80;
                        8'h3b: y = 8'he2;
                        8'h3c: y = 8'heb;
                        8'h3d: y = 8'h27;
                        8'h3e: y = 8'hb2;
                        8'h3f: y = 8'h75;
                        8'h40: y = 8'h09;
                        8'h41: y = 8'h83;
                        8'h42: y = 8'h2c;
                        8'h43: y = 8'h1a;
                        8'h44: y = 8'h1b;
                        8'h45: y = 8'h6e;
                        8'h46: y = 8'h5a;
                        8'h47: y = 8'ha0;
                        8'h48: y = 8'h52;
                        8'h49: y = 8'h3b;
                        8'h4a: y = 8'hd6;
                        8'h4b: y = 8'hb3;
                        8'h4c: y = 8'h29;
                        8'h4d: y = 8'he3;
                        8'h4e: y = 8'h2f;
                        8'h4f: y = 8'h84;
                        8'h50: y = 8'h53;
                        8'h51: y = 8'hd1;
                        8'h52: y = 8'h00;
                        8'h53: y = 8'hed;
                        8'h54: y = 8'h20;
                        8'h55: y = 8'hfc;
                        8'h56: y = 8'hb1;
                        8'h57: y = 8'h5b;
                        8'h58: y = 8'h6a;
                        8'h59: y = 8'hcb;
                        8'h5a: y = 8'hbe;
                        8'h5b: y = 8'h39;
                        8'h5c: y = 8'h4a;
                        8'h5d: y = 8'h4c;
                        8'h5e: y = 8'h58;
                        8'h5f: y = 8'hcf;
                        8'h60: y = 8'hd0;
                        8'h61: y = 8'hef;
                        8'h62: y = 8'haa;
                        8'h63: y = 8'hfb;
                        8'h64: y = 8'h43;
                        8'h65: y = 8'h4d;
                        8'h66: y = 8'h33;
                        8'h67: y = 8'h85;
                        8'h68: y = 8'h45;
                        8'h69: y = 8'hf9;
                        8'h6a: y = 8'h02;
                        8'h6b: y = 8'h7f;
                        8'h6c: y = 8'h50;
                        8'h6d: y = 8'h3c;
                        8'h6e: y = 8'h9f;
                        8'h6f: y = 8'ha8;
                        8'h70: y = 8'h51;
                        8'h71: y = 8'ha3;
                        8'h72: y = 8'h40;
                        8'h73: y = 8'h8f;
                        8'h74: y = 8'h92;
                        8'h75: y = 8'h9d;
                        8'h76: y = 8'h38;
                        8'h77: y = 8'hf5;
                        8'h78: y = 8'hbc;
                        8'h79: y = 8'hb6;
                        8'h7a: y = 8'hda;
                        8'h7b: y = 8'h21;
                        8'h7c: y = 8'h10;
                        8'h7d: y = 8'hff;
                        8'h7e: y = 8'hf3;
                        8'h7f: y = 8'hd2;
                        8'h80: y = 8'hcd;
                        8'h81: y = 8'h0c;
                        8'h82: y = 8'h13;
                        8'h83: y = 8'hec;
                        8'h84: y = 8'h5f;
                        8'h85: y = 8'h97;
                        8'h86: y = 8'h44;
                        8'h87: y = 8'h17;
                        8'h88: y = 8'hc4;
                        8'h89: y = 8'ha7;
                        8'h8a: y = 8'h7e;
                        8'h8b: y = 8'h3d;
                        8'h8c: y = 8'h64;
                        8'h8d: y = 8'h5d;
                        8'h8e: y = 8'h19;
                        8'h8f: y = 8'h73;
                        8'h90: y = 8'h60;
                        8'h91: y = 8'h81;
                        8'h92: y = 8'h4f;
                        8'h93: y = 8'hdc;
                        8'h94: y = 8'h22;
                        8'h95: y = 8'h2a;
                        8'h96: y = 8'h90;
                        8'h97: y = 8'h88;
                        8'h98: y = 8'h46;
                        8'h99: y = 8'hee;
                        8'h9a: y = 8'hb8;
                        8'h9b: y = 8'h14;
                        8'h9c: y = 8'hde;
                        8'h9d: y = 8'h5e;
                        8'h9e: y = 8'h0b;
                        8'h9f: y = 8'hdb;
                        8'ha0: y = 8'he0;
                        8'ha1: y = 8'h32;
                        8'ha2: y = 8'h3a;
                        8'ha3: y = 8'h0a;
                        8'ha4: y = 8'h49;
                        8'ha5: y = 8'h06;
                        8'ha6: y = 8'h24;
                        8'ha7: y = 8'h5c;
                        8'ha8: y = 8'hc2;
                        8'ha9: y = 8'hd3;
                        8'haa: y = 8'hac;
                        8'hab: y = 8'h62;
                        8'hac: y = 8'h91;
                        8'had: y = 8'h95;
                        8'hae: y = 8'he4;
                        8'haf: y = 8'h79;
                        8'hb0: y = 8'he7;
                        8'hb1: y = 8'hc8;
                        8'hb2: y = 8'h37;
                        8'hb3: y = 8'h6d;
                        8'hb4: y = 8'h8d;
                        8'hb5: y = 8'hd5;
                        8'hb6: y = 8'h4e;
                        8'hb7: y = 8'ha9;
                        8'hb8: y = 8'h6c;
                        8'hb9: y = 8'h56;
                        8'hba: y = 8'hf4;
                        8'hbb: y = 8'hea;
                        8'hbc: y = 8'h65;
                        8'hbd: y = 8'h7a;
                        8'hbe: y = 8'hae;
                        8'hbf: y = 8'h08;
                        8'hc0: y = 8'hba;
                        8'hc1: y = 8'h78;
                        8'hc2: y = 8'h25;
                        8'hc3: y = 8'h2e;
                        8'hc4: y = 8'h1c;
                        8'hc5: y = 8'ha6;
                        8'hc6: y = 8'hb4;
                        8'hc7: y = 8'hc6;
                        8'hc8: y = 8'he8;
                        8'hc9: y = 8'hdd;
                        8'hca: y = 8'h74;
                        8'hcb: y = 8'h1f;
                        8'hcc: y = 8'h4b;
                        8'hcd: y = 8'hbd;
                        8'hce: y = 8'h8b;
                        8'hcf: y = 8'h8a;
                        8'hd0: y = 8'h70;
                        8'hd1: y = 8'h3e;
                        8'hd2: y = 8'hb5;
                        8'hd3: y = 8'h66;
                        8'hd4: y = 8'h48;
                        8'hd5: y = 8'h03;
                        8'hd6: y = 8'hf6;
                        8'hd7: y = 8'h0e;
                        8'hd8: y = 8'h61;
                        8'hd9: y = 8'h35;
                        8'hda: y = 8'h57;
                        8'hdb: y = 8'hb9;
                        8'hdc: y = 8'h86;
                        8'hdd: y = 8'hc1;
                        8'hde: y = 8'h1d;
                        8'hdf: y = 8'h9e;
                        8'he0: y = 8'he1;
                        8'he1: y = 8'hf8;
                        8'he2: y = 8'h98;
                        8'he3: y = 8'h11;
                        8'he4: y = 8'h69;
                        8'he5: y = 8'hd9;
                        8'he6: y = 8'h8e;
                        8'he7: y = 8'h94;
                        8'he8: y = 8'h9b;
                        8'he9: y = 8'h1e;
                        8'hea: y = 8'h87;
                        8'heb: y = 8'he9;
                        8'hec: y = 8'hce;
                        8'hed: y = 8'h55;
                        8'hee: y = 8'h28;
                        8'hef: y = 8'hdf;
                        8'hf0: y = 8'h8c;
                        8'hf1: y = 8'ha1;
                        8'hf2: y = 8'h89;
                        8'hf3: y = 8'h0d;
                        8'hf4: y = 8'hbf;
                        8'hf5: y = 8'he6;
                        8'hf6: y = 8'h42;
                        8'hf7: y = 8'h68;
                        8'hf8: y = 8'h41;
                        8'hf9: y = 8'h99;
                        8'hfa: y = 8'h2d;
                        8'hfb: y = 8'h0f;
                        8'hfc: y = 8'hb0;
                        8'hfd: y = 8'h54;
                        8'hfe: y = 8'hbb;
                        8'hff: y = 8'h16;
                        default: y = 8'h00;  // Only reached for X or Z inputs
                endcase
        end

endmodule

`default_nettype wire

//--- shiftRowsStage.sv
`timescale 1ns/1ns
`default_nettype none

module shiftRowsStage import aesPkg::*; (
        input  logic     clk,
        input  logic     reset,
        input  logic     inValid,
        input  roundReqT inBlock,
        output logic     shiftedValid,
        output roundReqT shiftedReq
);

        stateT rotated;

        // Row r moves left by r columns
        always_comb begin
                for (int c = 0; c < 4; c++) begin
                        for (int r = 0; r < 4; r++) begin
                                rotated[4*c+r] = inBlock.state[4*((c+r)%4)+r];
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        shiftedValid <= 1'b0;
                end else begin
                        shiftedValid <= inValid;
                end
        end

        always_ff @(posedge clk) begin
                if (inValid) begin
                        shiftedReq.state    <= rotated;  // Held pre-shifted for the S-box array
                        shiftedReq.roundKey <= inBlock.roundKey;
                        shiftedReq.kind     <= inBlock.kind;
                end
        end

endmodule

`default_nettype wire

//--- mixColumnsStage.sv
`timescale 1ns/1ns
`default_nettype none

`include "aes_config.svh"

module mixColumnsStage import aesPkg::*; (
        input  logic      clk,
        input  logic      reset,
        input  logic      shiftedValid,
        input  stateT     subState,
        input  stateT     roundKey,
        input  roundKindT kind,
        output logic      outValid,
        output stateT     outState
);

        stateT                mixed;
        logic [`AES_WIDTH-1:0] keyed;

        // Multiply by x in GF(2^8)
        function automatic logic [7:0] xtime(input logic [7:0] b);
                return {b[6:0], 1'b0} ^ (b[7] ? `AES_POLY : 8'h00);
        endfunction

        // One column times the fixed matrix 02 03 01 01, rotated per row
        function automatic logic [31:0] mixWord(input logic [7:0] a0, input logic [7:0] a1,
                                                input logic [7:0] a2, input logic [7:0] a3);
                logic [7:0] b0;
                logic [7:0] b1;
                logic [7:0] b2;
                logic [7:0] b3;
                b0 = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
                b1 = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
                b2 = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
                b3 = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
                return {b0, b1, b2, b3};
        endfunction

        always_comb begin
                for (int c = 0; c < 4; c++) begin
                        if (kind == ROUND_MIX) begin
                                {mixed[4*c], mixed[4*c+1], mixed[4*c+2], mixed[4*c+3]} =
                                        mixWord(subState[4*c], subState[4*c+1],
                                                subState[4*c+2], subState[4*c+3]);
                        end else begin
                                {mixed[4*c], mixed[4*c+1], mixed[4*c+2], mixed[4*c+3]} =
                                        {subState[4*c], subState[4*c+1],
                                         subState[4*c+2], subState[4*c+3]};  // Final round
                        end
                end
        end

        assign keyed = mixed ^ roundKey;  // AddRoundKey

        always_ff @(posedge clk) begin
                if (reset) begin
                        outValid <= 1'b0;
                end else begin
                        outValid <= shiftedValid;
                end
        end

        always_ff @(posedge clk) begin
                if (shiftedValid) begin
                        outState <= keyed;
                end
        end

endmodule

`default_nettype wire

//--- aesRound.sv
`timescale 1ns/1ns
`default_nettype none

`include "aes_config.svh"

module aesRound import aesPkg::*; (
        input  logic     clk,
        input  logic     reset,
        input  logic     inValid,
        input  roundReqT inBlock,
        output logic     outValid,
        output stateT    outState
);

        logic     shiftedValid;
        roundReqT shiftedReq;
        stateT    subState;

        shiftRowsStage feeder (
                .clk          (clk),
                .reset        (reset),
                .inValid      (inValid),
                .inBlock      (inBlock),
                .shiftedValid (shiftedValid),
                .shiftedReq   (shiftedReq)
        );

        // One S-box per state byte, all in parallel
        for (genvar i = 0; i < `AES_BYTES; i++) begin : gSbox
                subBytes sbox (
                        .x (shiftedReq.state[i]),
                        .y (subState[i])
                );
        end

        mixColumnsStage drain (
                .clk          (clk),
                .reset        (reset),
                .shiftedValid (shiftedValid),
                .subState     (subState),
                .roundKey     (shiftedReq.roundKey),
                .kind         (shiftedReq.kind),
                .outValid     (outValid),
                .outState     (outState)
        );

endmodule

`default_nettype wire

//--- tbAesRound.sv
`timescale 1ns/1ns
`default_nettype none

`include "aes_config.svh"

module tbAesRound import aesPkg::*; ();

        logic      clk;
        logic      reset;
        logic      inValid;
        roundReqT  inBlock;
        logic      outValid;
        stateT     outState;

        int          errors;
        int          checks;
        logic [31:0] lfsr;
        logic [7:0]  sboxTable [0:255];

        aesRound dut (
                .clk      (clk),
                .reset    (reset),
                .inValid  (inValid),
                .inBlock  (inBlock),
                .outValid (outValid),
                .outState (outState)
        );

        always #50 clk = ~clk;

        // Taps 32, 22, 2, 1
        function automatic logic nextBit();
                logic fb;
                fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
                lfsr = {lfsr[30:0], fb};
                return fb;
        endfunction

        function automatic stateT randomState();
                logic [`AES_WIDTH-1:0] v;
                v = '0;
                for (int i = 0; i < `AES_WIDTH; i++) begin
                        v = {v[`AES_WIDTH-2:0], nextBit()};
                end
                return v;
        endfunction

        function automatic logic [7:0] gfDouble(input logic [7:0] a);
                return {a[6:0], 1'b0} ^ (a[7] ? `AES_POLY : 8'h00);
        endfunction

        function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
                logic [7:0] p;
                logic [7:0] x;
                logic [7:0] y;
                p = 8'h00;
                x = a;
                y = b;
                for (int i = 0; i < 8; i++) begin
                        if (y[0]) p = p ^ x;
                        x = gfDouble(x);
                        y = y >> 1;
                end
                return p;
        endfunction

        // Inverse is a^254, zero maps to zero
        function automatic logic [7:0] sboxValue(input logic [7:0] a);
                logic [7:0] inv;
                inv = (a == 8'h00) ? 8'h00 : 8'h01;
                if (a != 8'h00) begin
                        for (int i = 0; i < 254; i++) inv = gfMul(inv, a);
                end
                return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
                       {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
        endfunction

        function automatic stateT rowShift(input stateT s);
                stateT t;
                for (int c = 0; c < 4; c++) begin
                        for (int r = 0; r < 4; r++) t[4*c+r] = s[4*((c+r)%4)+r];
                end
                return t;
        endfunction

        function automatic stateT columnMix(input stateT s);
                stateT m;
                for (int c = 0; c < 4; c++) begin
                        m[4*c]   = gfMul(s[4*c], 8'h02) ^ gfMul(s[4*c+1], 8'h03) ^
                                   s[4*c+2] ^ s[4*c+3];
                        m[4*c+1] = s[4*c] ^ gfMul(s[4*c+1], 8'h02) ^
                                   gfMul(s[4*c+2], 8'h03) ^ s[4*c+3];
                        m[4*c+2] = s[4*c] ^ s[4*c+1] ^ gfMul(s[4*c+2], 8'h02) ^
                                   gfMul(s[4*c+3], 8'h03);
                        m[4*c+3] = gfMul(s[4*c], 8'h03) ^ s[4*c+1] ^ s[4*c+2] ^
                                   gfMul(s[4*c+3], 8'h02);
                end
                return m;
        endfunction

        function automatic stateT roundModel(input roundReqT req);
                stateT t;
                t = rowShift(req.state);
                for (int i = 0; i < `AES_BYTES; i++) t[i] = sboxTable[t[i]];
                if (req.kind == ROUND_MIX) t = columnMix(t);
                return t ^ req.roundKey;
        endfunction

        task automatic checkState(input string name, input stateT got, input stateT expected);
                checks++;
                if (got !== expected) begin
                        errors++;
                        $display("[FAIL] %s: got %h, expected %h", name, got, expected);
                end
        endtask

        task automatic checkValid(input string name, input logic got, input logic expected);
                checks++;
                if (got !== expected) begin
                        errors++;
                        $display("[FAIL] %s: got %h, expected %h", name, got, expected);
                end
        endtask

        task automatic sendRequest(input roundReqT req);
                inBlock = req;
                inValid = 1'b1;
                @(negedge clk);
                inValid = 1'b0;
        endtask

        task automatic waitResult(output logic arrived);
                arrived = 1'b0;
                for (int n = 0; n < 20 && !arrived; n++) begin
                        if (outValid === 1'b1) arrived = 1'b1;
                        else @(negedge clk);
                end
                if (!arrived) begin
                        errors++;
                        $display("No result arrived within 20 cycles of a request");
                end
        endtask

        task automatic holdReset();
                reset = 1'b1;
                for (int n = 0; n < 16; n++) begin
                        @(negedge clk);
                        checkValid("outValid", outValid, 1'b0);
                end
                reset = 1'b0;
        endtask

        task automatic testResetIdle();
                holdReset();
                for (int n = 0; n < 10; n++) begin
                        @(negedge clk);
                        checkValid("outValid", outValid, 1'b0);
                end
        endtask

        task automatic testFipsRound();
                roundReqT req;
                logic     arrived;
                req.state    = 128'h193de3bea0f4e22b9ac68d2ae9f84808;
                req.roundKey = 128'ha0fafe1788542cb123a339392a6c7605;
                req.kind     = ROUND_MIX;
                checkState("model", roundModel(req), 128'ha49c7ff2689f352b6b5bea43026a5049);
                sendRequest(req);
                waitResult(arrived);
                if (arrived) begin
                        checkState("outState", outState, 128'ha49c7ff2689f352b6b5bea43026a5049);
                        checkState("outState", outState, roundModel(req));
                end
                @(negedge clk);
        endtask

        // Request k holds bytes 16k to 16k+15, so all 256 table entries are hit
        task automatic testSboxSweep();
                roundReqT req;
                logic     arrived;
                for (int k = 0; k < 16; k++) begin
                        for (int i = 0; i < `AES_BYTES; i++) req.state[i] = 8'(16 * k + i);
                        req.roundKey = '0;
                        req.kind     = ROUND_FINAL;
                        sendRequest(req);
                        waitResult(arrived);
                        if (arrived) checkState("outState", outState, roundModel(req));
                        @(negedge clk);
                end
        endtask

        task automatic testStream();
                roundReqT reqs [0:31];
                for (int k = 0; k < 32; k++) begin
                        reqs[k].state    = randomState();
                        reqs[k].roundKey = randomState();
                        reqs[k].kind     = roundKindT'(nextBit());
                end
                for (int t = 0; t < 34; t++) begin
                        if (t >= 2) begin
                                checkValid("outValid", outValid, 1'b1);
                                checkState("outState", outState, roundModel(reqs[t-2]));
                        end else begin
                                checkValid("outValid", outValid, 1'b0);
                        end
                        inValid = (t < 32);
                        if (t < 32) inBlock = reqs[t];
                        @(negedge clk);
                end
                checkValid("outValid", outValid, 1'b0);
        endtask

        task automatic testResetFlush();
                roundReqT req;
                logic     arrived;
                req.state    = randomState();
                req.roundKey = randomState();
                req.kind     = ROUND_MIX;
                inBlock = req;
                inValid = 1'b1;
                @(negedge clk);
                inBlock.state = randomState();  // Second request lands with reset
                reset = 1'b1;
                @(negedge clk);
                inValid = 1'b0;
                checkValid("outValid", outValid, 1'b0);
                holdReset();
                for (int n = 0; n < 5; n++) begin
                        @(negedge clk);
                        checkValid("outValid", outValid, 1'b0);
                end
                req.kind = ROUND_FINAL;
                sendRequest(req);
                waitResult(arrived);
                if (arrived) checkState("outState", outState, roundModel(req));
                @(negedge clk);
        endtask

        initial begin
                clk     = 1'b0;
                reset   = 1'b1;
                inValid = 1'b0;
                inBlock = '0;
                errors  = 0;
                checks  = 0;
                lfsr    = 32'h0f347fac;
                for (int a = 0; a < 256; a++) sboxTable[a] = sboxValue(8'(a));

                testResetIdle();
                testFipsRound();
                testSboxSweep();
                testStream();
                testResetFlush();

                $display("Checks: %0d, errors: %0d", checks, errors);
                if (errors == 0) begin
                        $display("PASS: all tests");
                end else begin
                        $display("FAIL: see errors above");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
aesPkg.sv
subBytes.sv
shiftRowsStage.sv
mixColumnsStage.sv
aesRound.sv
tbAesRound.sv

//--- Makefile
TOP = tbAesRound

.PHONY: all lint clean

all:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

lint:
	verilator --lint-only -Wall +incdir+. --top-module aesRound \
		aesPkg.sv subBytes.sv shiftRowsStage.sv mixColumnsStage.sv aesRound.sv

clean:
	rm -rf obj_dir
